// ==== design/cpu_pkg.sv ====
package cpu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Bus and timing
  // ~~~~~~~~~~~~~~~~~~~~

  localparam int ADDR_W   = 16;
  localparam int DATA_W   = 8;
  localparam int T_STATES = 4;  // Clocks per machine cycle.
  localparam int MCYC_W   = 2;

  localparam logic [ADDR_W-1:0] RESET_PC = 16'h0100;

  // Machine-cycle indices, M1 is the opcode fetch.
  localparam logic [MCYC_W-1:0] M1 = 2'd0;
  localparam logic [MCYC_W-1:0] M2 = 2'd1;
  localparam logic [MCYC_W-1:0] M3 = 2'd2;

  // ~~~~~~~~~~~~~~~~~~~~
  // Instruction fields
  // ~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [2:0] {
    REG_B      = 3'd0,
    REG_C      = 3'd1,
    REG_D      = 3'd2,
    REG_E      = 3'd3,
    REG_H      = 3'd4,
    REG_L      = 3'd5,
    REG_HL_MEM = 3'd6,  // Operand is the byte at (HL).
    REG_A      = 3'd7
  } reg_idx_t;

  typedef enum logic [1:0] {
    PAIR_BC = 2'd0,
    PAIR_DE = 2'd1,
    PAIR_HL = 2'd2
  } pair_t;

  typedef enum logic [3:0] {
    OP_NOP,
    OP_LD_R_R,
    OP_LD_R_IMM,
    OP_LD_R_HL,
    OP_LD_HL_R,
    OP_LD_HL_IMM,
    OP_ST_PAIR_A,
    OP_LD_A_PAIR,
    OP_ST_HLI_A,
    OP_LD_A_HLI,
    OP_LD_PAIR_IMM,
    OP_INC_PAIR
  } op_t;

  typedef struct packed {
    op_t               op;
    reg_idx_t          dst;
    reg_idx_t          src;
    pair_t             pair;
    logic              hl_dec;    // HL steps down after the access.
    logic [MCYC_W-1:0] m_cycles;  // Total machine cycles, 1 to 3.
  } decoded_t;

  typedef struct packed {
    logic              byte_en;
    reg_idx_t          byte_idx;
    logic [DATA_W-1:0] byte_data;
    logic              pair_en;
    pair_t             pair;
    logic [ADDR_W-1:0] pair_data;
  } reg_wr_t;

  typedef struct packed {
    logic              en;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } mem_wr_t;

endpackage

// ==== design/instr_decoder.sv ====
module instr_decoder import cpu_pkg::*; (
  input  logic [DATA_W-1:0] i_ir,
  output decoded_t          o_dec
);

  reg_idx_t          dst_field;
  reg_idx_t          src_field;
  op_t               op;
  reg_idx_t          dst;
  reg_idx_t          src;
  pair_t             pair;
  logic              hl_dec;
  logic [MCYC_W-1:0] m_cycles;

  assign dst_field = reg_idx_t'(i_ir[5:3]);
  assign src_field = reg_idx_t'(i_ir[2:0]);

  // ~~~~~~~~~~~~~~~~~~~~
  // Opcode classes
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    op     = OP_NOP;
    dst    = dst_field;
    src    = src_field;
    pair   = PAIR_HL;  // Every (HL) form addresses through HL.
    hl_dec = 1'b0;

    if (i_ir[7:6] == 2'b01) begin
      if (dst_field == REG_HL_MEM && src_field == REG_HL_MEM) begin
        op = OP_NOP;  // Opcode 76 is not executed.
      end else if (dst_field == REG_HL_MEM) begin
        op = OP_LD_HL_R;
      end else if (src_field == REG_HL_MEM) begin
        op = OP_LD_R_HL;
      end else begin
        op = OP_LD_R_R;
      end
    end else if (i_ir[7:6] == 2'b00) begin
      if (src_field == REG_HL_MEM) begin
        op = (dst_field == REG_HL_MEM) ? OP_LD_HL_IMM : OP_LD_R_IMM;
      end else begin
        case (i_ir[3:0])
          4'h1: begin
            if (i_ir[5:4] != 2'b11) begin
              op   = OP_LD_PAIR_IMM;
              pair = pair_t'(i_ir[5:4]);
            end
          end
          4'h3: begin
            if (i_ir[5:4] != 2'b11) begin
              op   = OP_INC_PAIR;
              pair = pair_t'(i_ir[5:4]);
            end
          end
          4'h2: begin
            src = REG_A;
            if (!i_ir[5]) begin
              op   = OP_ST_PAIR_A;
              pair = pair_t'(i_ir[5:4]);
            end else begin
              op     = OP_ST_HLI_A;
              hl_dec = i_ir[4];
            end
          end
          4'hA: begin
            dst = REG_A;
            if (!i_ir[5]) begin
              op   = OP_LD_A_PAIR;
              pair = pair_t'(i_ir[5:4]);
            end else begin
              op     = OP_LD_A_HLI;
              hl_dec = i_ir[4];
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (op)
      OP_NOP, OP_LD_R_R:             m_cycles = 2'd1;
      OP_LD_HL_IMM, OP_LD_PAIR_IMM:  m_cycles = 2'd3;
      default:                       m_cycles = 2'd2;
    endcase
  end

  assign o_dec = '{op: op, dst: dst, src: src, pair: pair, hl_dec: hl_dec,
                   m_cycles: m_cycles};

endmodule

// ==== design/mcycle_timer.sv ====
module mcycle_timer import cpu_pkg::*; (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic [MCYC_W-1:0] i_m_cycles,
  output logic [1:0]        o_t_state,
  output logic [MCYC_W-1:0] o_m_cycle,
  output logic              o_instr_end
);

  logic t_last;
  logic m_last;

  assign t_last = (o_t_state == 2'(T_STATES - 1));
  assign m_last = (o_m_cycle == i_m_cycles - MCYC_W'(1));

  // The decode of a new opcode is only valid from T3 of M1 on.
  assign o_instr_end = t_last && m_last;

  always_ff @(posedge i_clk, posedge i_rst) begin
    if (i_rst) begin
      o_t_state <= '0;
      o_m_cycle <= '0;
    end else if (t_last) begin
      o_t_state <= '0;
      if (m_last) begin
        o_m_cycle <= '0;
      end else begin
        o_m_cycle <= o_m_cycle + MCYC_W'(1);
      end
    end else begin
      o_t_state <= o_t_state + 2'd1;
    end
  end

endmodule

// ==== design/reg_file.sv ====
module reg_file import cpu_pkg::*; (
  input  logic              i_clk,
  input  logic              i_rst,
  input  reg_idx_t          i_rd_a_idx,
  input  reg_idx_t          i_rd_b_idx,
  input  reg_wr_t           i_wr,
  output logic [DATA_W-1:0] o_rd_a,
  output logic [DATA_W-1:0] o_rd_b
);

  logic [DATA_W-1:0] r_a;
  logic [DATA_W-1:0] r_b;
  logic [DATA_W-1:0] r_c;
  logic [DATA_W-1:0] r_d;
  logic [DATA_W-1:0] r_e;
  logic [DATA_W-1:0] r_h;
  logic [DATA_W-1:0] r_l;

  function automatic logic [DATA_W-1:0] read_reg(reg_idx_t idx);
    case (idx)
      REG_B:   return r_b;
      REG_C:   return r_c;
      REG_D:   return r_d;
      REG_E:   return r_e;
      REG_H:   return r_h;
      REG_L:   return r_l;
      REG_A:   return r_a;
      default: return '0;  // Memory code has no register behind it.
    endcase
  endfunction

  always_comb begin
    o_rd_a = read_reg(i_rd_a_idx);
    o_rd_b = read_reg(i_rd_b_idx);
  end

  always_ff @(posedge i_clk, posedge i_rst) begin
    if (i_rst) begin
      r_a <= '0;
      r_b <= '0;
      r_c <= '0;
      r_d <= '0;
      r_e <= '0;
      r_h <= '0;
      r_l <= '0;
    end else begin
      if (i_wr.byte_en) begin
        case (i_wr.byte_idx)
          REG_B:   r_b <= i_wr.byte_data;
          REG_C:   r_c <= i_wr.byte_data;
          REG_D:   r_d <= i_wr.byte_data;
          REG_E:   r_e <= i_wr.byte_data;
          REG_H:   r_h <= i_wr.byte_data;
          REG_L:   r_l <= i_wr.byte_data;
          REG_A:   r_a <= i_wr.byte_data;
          default: ;
        endcase
      end
      if (i_wr.pair_en) begin  // Later assignment gives the pair priority.
        case (i_wr.pair)
          PAIR_BC: {r_b, r_c} <= i_wr.pair_data;
          PAIR_DE: {r_d, r_e} <= i_wr.pair_data;
          PAIR_HL: {r_h, r_l} <= i_wr.pair_data;
          default: ;
        endcase
      end
    end
  end

endmodule

// ==== design/cpu_sequencer.sv ====
module cpu_sequencer import cpu_pkg::*; (
  input  logic              i_clk,
  input  logic              i_rst,

  input  logic [DATA_W-1:0] i_mem_rd_data,
  output logic [ADDR_W-1:0] o_mem_rd_addr,
  output mem_wr_t           o_mem_wr,

  output logic [DATA_W-1:0] o_ir,
  input  decoded_t          i_dec,

  input  logic [1:0]        i_t_state,
  input  logic [MCYC_W-1:0] i_m_cycle,
  input  logic              i_instr_end,

  output reg_idx_t          o_rd_a_idx,
  output reg_idx_t          o_rd_b_idx,
  input  logic [DATA_W-1:0] i_rd_a,
  input  logic [DATA_W-1:0] i_rd_b,
  output reg_wr_t           o_reg_wr
);

  logic [ADDR_W-1:0] pc;
  logic [ADDR_W-1:0] pc_next;
  logic [ADDR_W-1:0] bus_addr;
  logic [ADDR_W-1:0] next_addr;
  logic [DATA_W-1:0] ir;
  logic [ADDR_W-1:0] opnd;
  logic [ADDR_W-1:0] pair_val;
  logic [ADDR_W-1:0] step_sum;
  logic [DATA_W-1:0] wr_src;
  logic [DATA_W-1:0] wr_data;
  logic              wr_en;
  logic              t_last;
  logic [MCYC_W-1:0] next_m;
  reg_idx_t          pair_hi;
  reg_idx_t          pair_lo;

  // ~~~~~~~~~~~~~~~~~~~~
  // Cycle usage per op
  // ~~~~~~~~~~~~~~~~~~~~

  function automatic logic pc_cycle(op_t op, logic [MCYC_W-1:0] m);
    logic imm_op;
    imm_op = op inside {OP_LD_R_IMM, OP_LD_HL_IMM, OP_LD_PAIR_IMM};
    return (m == M1) || (m == M2 && imm_op) || (m == M3 && op == OP_LD_PAIR_IMM);
  endfunction

  function automatic logic pair_cycle(op_t op, logic [MCYC_W-1:0] m);
    case (m)
      M2:      return op inside {OP_LD_R_HL, OP_LD_HL_R, OP_ST_PAIR_A,
                                 OP_LD_A_PAIR, OP_ST_HLI_A, OP_LD_A_HLI};
      M3:      return op == OP_LD_HL_IMM;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic write_cycle(op_t op, logic [MCYC_W-1:0] m);
    case (m)
      M2:      return op inside {OP_LD_HL_R, OP_ST_PAIR_A, OP_ST_HLI_A};
      M3:      return op == OP_LD_HL_IMM;
      default: return 1'b0;
    endcase
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // Register reads
  // ~~~~~~~~~~~~~~~~~~~~

  assign t_last  = (i_t_state == 2'(T_STATES - 1));
  assign pair_hi = reg_idx_t'({i_dec.pair, 1'b0});
  assign pair_lo = reg_idx_t'({i_dec.pair, 1'b1});

  // At T3 the ports show the pair, or the source of a register move.
  assign o_rd_a_idx = t_last ? pair_hi : i_dec.src;
  assign o_rd_b_idx = (i_dec.op == OP_LD_R_R) ? i_dec.src : pair_lo;

  assign pair_val = {i_rd_a, i_rd_b};
  assign step_sum = pair_val + (i_dec.hl_dec ? 16'hFFFF : 16'h0001);

  // ~~~~~~~~~~~~~~~~~~~~
  // Bus address
  // ~~~~~~~~~~~~~~~~~~~~

  assign pc_next   = pc_cycle(i_dec.op, i_m_cycle) ? pc + 16'd1 : pc;
  assign next_m    = i_m_cycle + MCYC_W'(1);
  assign next_addr = pair_cycle(i_dec.op, next_m) ? pair_val : pc_next;

  assign wr_src = (i_dec.op == OP_LD_HL_IMM) ? opnd[DATA_W-1:0] : i_rd_a;

  always_ff @(posedge i_clk, posedge i_rst) begin
    if (i_rst) begin
      pc       <= RESET_PC;
      bus_addr <= RESET_PC;
      ir       <= '0;  // Decodes as NOP.
      wr_en    <= 1'b0;
    end else begin
      case (i_t_state)
        2'd1: wr_en <= write_cycle(i_dec.op, i_m_cycle);  // Strobe covers T2.
        2'd2: begin
          wr_en <= 1'b0;
          if (i_m_cycle == M1) begin
            ir <= i_mem_rd_data;
          end
        end
        2'd3: begin
          pc       <= pc_next;
          bus_addr <= next_addr;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_t_state == 2'd1 && write_cycle(i_dec.op, i_m_cycle)) begin
      wr_data <= wr_src;
    end
    if (i_t_state == 2'd2) begin
      if (i_m_cycle == M2) begin
        opnd[DATA_W-1:0] <= i_mem_rd_data;  // Immediate, low byte or loaded data.
      end else if (i_m_cycle == M3) begin
        opnd[ADDR_W-1:DATA_W] <= i_mem_rd_data;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Register writes
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    o_reg_wr.byte_en   = i_instr_end &&
                         (i_dec.op inside {OP_LD_R_R, OP_LD_R_IMM, OP_LD_R_HL,
                                           OP_LD_A_PAIR, OP_LD_A_HLI});
    o_reg_wr.byte_idx  = i_dec.dst;
    o_reg_wr.byte_data = (i_dec.op == OP_LD_R_R) ? i_rd_b : opnd[DATA_W-1:0];
    o_reg_wr.pair_en   = i_instr_end &&
                         (i_dec.op inside {OP_LD_PAIR_IMM, OP_INC_PAIR,
                                           OP_ST_HLI_A, OP_LD_A_HLI});
    o_reg_wr.pair      = i_dec.pair;
    o_reg_wr.pair_data = (i_dec.op == OP_LD_PAIR_IMM) ? opnd : step_sum;
  end

  assign o_ir          = ir;
  assign o_mem_rd_addr = bus_addr;
  assign o_mem_wr      = '{en: wr_en, addr: bus_addr, data: wr_data};

endmodule

// ==== design/cpu_top.sv ====
module cpu_top import cpu_pkg::*; (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic [DATA_W-1:0] i_mem_rd_data,
  output logic [ADDR_W-1:0] o_mem_rd_addr,
  output mem_wr_t           o_mem_wr
);

  logic [DATA_W-1:0] ir;
  decoded_t          dec;
  logic [1:0]        t_state;
  logic [MCYC_W-1:0] m_cycle;
  logic              instr_end;
  reg_idx_t          rd_a_idx;
  reg_idx_t          rd_b_idx;
  logic [DATA_W-1:0] rd_a;
  logic [DATA_W-1:0] rd_b;
  reg_wr_t           reg_wr;

  instr_decoder u_instr_decoder (
    .i_ir  (ir),
    .o_dec (dec)
  );

  mcycle_timer u_mcycle_timer (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_m_cycles  (dec.m_cycles),
    .o_t_state   (t_state),
    .o_m_cycle   (m_cycle),
    .o_instr_end (instr_end)
  );

  reg_file u_reg_file (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rd_a_idx (rd_a_idx),
    .i_rd_b_idx (rd_b_idx),
    .i_wr       (reg_wr),
    .o_rd_a     (rd_a),
    .o_rd_b     (rd_b)
  );

  cpu_sequencer u_cpu_sequencer (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_mem_rd_data (i_mem_rd_data),
    .o_mem_rd_addr (o_mem_rd_addr),
    .o_mem_wr      (o_mem_wr),
    .o_ir          (ir),
    .i_dec         (dec),
    .i_t_state     (t_state),
    .i_m_cycle     (m_cycle),
    .i_instr_end   (instr_end),
    .o_rd_a_idx    (rd_a_idx),
    .o_rd_b_idx    (rd_b_idx),
    .i_rd_a        (rd_a),
    .i_rd_b        (rd_b),
    .o_reg_wr      (reg_wr)
  );

endmodule

// ==== tb/tb_clock_gen.sv ====
module tb_clock_gen (
  input  logic i_rst_req,
  output logic o_clk,
  output logic o_rst
);

  logic init_rst;

  always begin
    o_clk = 1'b0;
    #2;
    o_clk = 1'b1;
    #2;
  end

  initial begin
    init_rst = 1'b1;
    repeat (2) @(posedge o_clk);
    @(negedge o_clk);
    init_rst = 1'b0;  // Released on a falling edge.
  end

  assign o_rst = init_rst | i_rst_req;

endmodule

// ==== tb/tb_memory.sv ====
module tb_memory import cpu_pkg::*; (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic [ADDR_W-1:0] i_addr,
  output logic [DATA_W-1:0] o_data,
  input  mem_wr_t           i_wr,
  input  logic              i_load_en,
  input  logic [ADDR_W-1:0] i_load_addr,
  input  logic [DATA_W-1:0] i_load_data
);

  logic [DATA_W-1:0] mem [65536];
  int                clk_count;
  mem_wr_t           log_wr[$];
  int                log_clk[$];

  assign o_data = mem[i_addr];  // Reads answer in the same clock.

  always @(posedge i_clk) begin
    if (i_load_en) begin
      mem[i_load_addr] <= i_load_data;
    end else if (i_wr.en) begin
      mem[i_wr.addr] <= i_wr.data;
    end
  end

  // Each write is logged with the clocks counted since reset release.
  always @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      clk_count <= 0;
      log_wr.delete();
      log_clk.delete();
    end else begin
      if (i_wr.en) begin
        log_wr.push_back(i_wr);
        log_clk.push_back(clk_count);
      end
      clk_count <= clk_count + 1;
    end
  end

endmodule

// ==== tb/cpu_tb.sv ====
module cpu_tb import cpu_pkg::*; ;

  logic              clk;
  logic              rst;
  logic              rst_req;
  logic              load_en;
  logic [ADDR_W-1:0] load_addr;
  logic [DATA_W-1:0] load_data;
  logic [ADDR_W-1:0] mem_rd_addr;
  logic [DATA_W-1:0] mem_rd_data;
  mem_wr_t           mem_wr;

  logic [31:0]       lfsr;
  logic [7:0]        image [65536];
  logic [7:0]        model_mem [65536];
  logic [7:0]        regs [8];
  logic [7:0]        prog[$];
  mem_wr_t           exp_wr[$];
  int                exp_clk[$];
  int                model_cycles;
  int                fail_count;
  int                reset_errs;
  int                tests_run;
  int                tests_failed;
  bit                timed_out;
  logic [2:0]        r_list [8];

  tb_clock_gen u_clk_gen (.i_rst_req(rst_req), .o_clk(clk), .o_rst(rst));

  cpu_top i_cpu_top (
    .i_clk         (clk),
    .i_rst         (rst),
    .i_mem_rd_data (mem_rd_data),
    .o_mem_rd_addr (mem_rd_addr),
    .o_mem_wr      (mem_wr)
  );

  tb_memory mem_model (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_addr      (mem_rd_addr),
    .o_data      (mem_rd_data),
    .i_wr        (mem_wr),
    .i_load_en   (load_en),
    .i_load_addr (load_addr),
    .i_load_data (load_data)
  );

  always @(negedge clk) begin
    if (rst) begin
      assert (!mem_wr.en) else begin
        $display("Write strobe was active while reset was held.");
        reset_errs++;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Stimulus helpers
  // ~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [31:0] v;
    v = rand_bits(8);
    return v[7:0];
  endfunction

  function automatic logic [15:0] rand_data_addr();
    logic [31:0] v;
    v = rand_bits(14);
    return {2'b10, v[13:0]};  // Data lives in 8000-BFFF, clear of the code.
  endfunction

  function automatic logic [7:0] fill_byte(logic [15:0] a);
    return a[15:8] ^ {a[6:0], a[7]} ^ 8'hA5;
  endfunction

  function automatic int total_errors();
    return fail_count + reset_errs;
  endfunction

  task automatic emit(input logic [7:0] b);
    prog.push_back(b);
  endtask

  task automatic emit_ld_r_imm(input logic [2:0] r, input logic [7:0] v);
    emit({2'b00, r, 3'b110});
    emit(v);
  endtask

  task automatic emit_ld_r_r(input logic [2:0] d, input logic [2:0] s);
    emit({2'b01, d, s});
  endtask

  task automatic emit_ld_pair_imm(input logic [1:0] p, input logic [15:0] v);
    emit({2'b00, p, 4'h1});
    emit(v[7:0]);
    emit(v[15:8]);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~

  function automatic logic [15:0] get_pair(logic [1:0] p);
    return {regs[{p, 1'b0}], regs[{p, 1'b1}]};
  endfunction

  task automatic set_pair(input logic [1:0] p, input logic [15:0] v);
    regs[{p, 1'b0}] = v[15:8];
    regs[{p, 1'b1}] = v[7:0];
  endtask

  task automatic store(input logic [15:0] a, input logic [7:0] d, input int mc, input int off);
    mem_wr_t w;
    w = '{en: 1'b1, addr: a, data: d};
    exp_wr.push_back(w);
    exp_clk.push_back(4 * mc + 4 * off + 2);  // Strobe sits in T2.
    model_mem[a] = d;
  endtask

  task automatic run_model(input logic [15:0] end_addr);
    logic [15:0] pc;
    logic [7:0]  op;
    logic [7:0]  imm;
    logic [2:0]  d;
    logic [2:0]  s;
    int          mc;
    exp_wr.delete();
    exp_clk.delete();
    for (int i = 0; i < 8; i++) regs[3'(i)] = 8'h00;
    mc = 0;
    pc = RESET_PC;
    while (pc < end_addr) begin
      op = model_mem[pc];
      pc = pc + 16'd1;
      d  = op[5:3];
      s  = op[2:0];
      if (op[7:6] == 2'b01 && op != 8'h76) begin
        if (d == 3'd6) begin
          store(get_pair(2'd2), regs[s], mc, 1);
          mc += 2;
        end else if (s == 3'd6) begin
          regs[d] = model_mem[get_pair(2'd2)];
          mc += 2;
        end else begin
          regs[d] = regs[s];
          mc += 1;
        end
      end else if (op[7:6] == 2'b00 && s == 3'd6) begin
        imm = model_mem[pc];
        pc  = pc + 16'd1;
        if (d == 3'd6) begin
          store(get_pair(2'd2), imm, mc, 2);
          mc += 3;
        end else begin
          regs[d] = imm;
          mc += 2;
        end
      end else if (op[7:6] == 2'b00 && op[5:4] != 2'b11 && op[3:0] == 4'h1) begin
        set_pair(op[5:4], {model_mem[pc + 16'd1], model_mem[pc]});
        pc = pc + 16'd2;
        mc += 3;
      end else if (op[7:6] == 2'b00 && op[5:4] != 2'b11 && op[3:0] == 4'h3) begin
        set_pair(op[5:4], get_pair(op[5:4]) + 16'd1);
        mc += 2;
      end else if (op == 8'h02 || op == 8'h12) begin
        store(get_pair(op[5:4]), regs[7], mc, 1);
        mc += 2;
      end else if (op == 8'h0A || op == 8'h1A) begin
        regs[7] = model_mem[get_pair(op[5:4])];
        mc += 2;
      end else if (op == 8'h22 || op == 8'h32) begin
        store(get_pair(2'd2), regs[7], mc, 1);
        set_pair(2'd2, op[4] ? get_pair(2'd2) - 16'd1 : get_pair(2'd2) + 16'd1);
        mc += 2;
      end else if (op == 8'h2A || op == 8'h3A) begin
        regs[7] = model_mem[get_pair(2'd2)];
        set_pair(2'd2, op[4] ? get_pair(2'd2) - 16'd1 : get_pair(2'd2) + 16'd1);
        mc += 2;
      end else begin
        mc += 1;  // Everything else is a one-cycle NOP.
      end
    end
    model_cycles = mc;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Run and check
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic restart();
    @(negedge clk);
    rst_req = 1'b1;
    for (int a = 0; a < 65536; a++) begin
      load_en   = 1'b1;
      load_addr = 16'(a);
      load_data = image[16'(a)];
      @(negedge clk);
    end
    load_en = 1'b0;
    repeat (2) @(negedge clk);
    rst_req = 1'b0;
  endtask

  task automatic check_log(input string name);
    int n;
    n = mem_model.log_wr.size();
    assert (n == exp_wr.size()) else begin
      $display("[FAIL] %s write count: expected %0d, actual %0d", name, exp_wr.size(), n);
      fail_count++;
    end
    for (int i = 0; i < n && i < exp_wr.size(); i++) begin
      assert (mem_model.log_wr[i].addr == exp_wr[i].addr) else begin
        $display("[FAIL] %s write %0d addr: expected %h, actual %h", name, i,
                 exp_wr[i].addr, mem_model.log_wr[i].addr);
        fail_count++;
      end
      assert (mem_model.log_wr[i].data == exp_wr[i].data) else begin
        $display("[FAIL] %s write %0d data: expected %h, actual %h", name, i,
                 exp_wr[i].data, mem_model.log_wr[i].data);
        fail_count++;
      end
      assert (mem_model.log_clk[i] == exp_clk[i]) else begin
        $display("[FAIL] %s write %0d clock: expected %0d, actual %0d", name, i,
                 exp_clk[i], mem_model.log_clk[i]);
        fail_count++;
      end
    end
  endtask

  task automatic run_program(input string name);
    logic [15:0] end_addr;
    int          limit;
    int          waited;
    int          start_errs;
    start_errs = total_errors();
    end_addr   = RESET_PC + 16'(prog.size());
    for (int a = 0; a < 65536; a++) image[16'(a)] = fill_byte(16'(a));
    foreach (prog[i]) image[RESET_PC + 16'(i)] = prog[i];
    for (int i = 0; i < 4; i++) image[end_addr + 16'(i)] = 8'h00;
    for (int a = 0; a < 65536; a++) model_mem[16'(a)] = image[16'(a)];
    run_model(end_addr);
    restart();
    assert (mem_rd_addr == RESET_PC) else begin
      $display("[FAIL] %s first fetch: expected %h, actual %h", name, RESET_PC, mem_rd_addr);
      fail_count++;
    end
    limit  = 4 * model_cycles + 64;
    waited = 0;
    while (mem_rd_addr != end_addr && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (mem_rd_addr != end_addr) begin
      $display("%s: timed out, no fetch from %h within %0d clocks.", name, end_addr, limit);
      timed_out = 1'b1;
      fail_count++;
    end else begin
      assert (mem_model.clk_count == 4 * model_cycles) else begin
        $display("[FAIL] %s end clock: expected %0d, actual %0d", name,
                 4 * model_cycles, mem_model.clk_count);
        fail_count++;
      end
      check_log(name);
    end
    prog.delete();
    tests_run++;
    if (total_errors() == start_errs) begin
      $display("%s: ok, %0d writes", name, exp_wr.size());
    end else begin
      $display("%s: %0d failed checks", name, total_errors() - start_errs);
      tests_failed++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Tests
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic test_reset_state();
    emit_ld_r_imm(REG_A, rand_byte());
    emit_ld_pair_imm(PAIR_HL, rand_data_addr());
    emit(8'h00);
    emit_ld_r_r(REG_HL_MEM, REG_A);
    run_program("reset_state");
  endtask

  task automatic test_imm_and_store();
    logic [7:0] v;
    for (int i = 0; i < 7; i++) begin
      v = rand_byte();
      if (r_list[3'(i)] == REG_H) begin
        v = {2'b10, v[5:0]};  // Stores through HL land in 8000-BFFF.
      end
      emit_ld_r_imm(r_list[3'(i)], v);
    end
    for (int i = 0; i < 7; i++) begin
      emit_ld_r_r(REG_HL_MEM, r_list[3'(i)]);
      emit({2'b00, PAIR_HL, 4'h3});  // Next store goes one byte up.
    end
    emit_ld_pair_imm(PAIR_HL, rand_data_addr());
    emit_ld_r_imm(REG_HL_MEM, rand_byte());
    run_program("imm_and_store");
  endtask

  task automatic test_reg_moves();
    logic [2:0]  lo_list [4];
    logic [31:0] v;
    lo_list = '{REG_C, REG_E, REG_L, REG_A};  // Moves keep the pointer high bytes.
    emit_ld_pair_imm(PAIR_BC, rand_data_addr());
    emit_ld_pair_imm(PAIR_DE, rand_data_addr());
    emit_ld_pair_imm(PAIR_HL, rand_data_addr());
    emit_ld_r_imm(REG_A, rand_byte());
    for (int round = 0; round < 3; round++) begin
      for (int i = 0; i < 4; i++) begin
        v = rand_bits(5);
        emit_ld_r_r(lo_list[v[4:3]], r_list[v[2:0]]);
      end
      emit(8'h02);
      emit(8'h12);
      emit_ld_r_r(REG_HL_MEM, REG_C);
      emit_ld_r_r(REG_HL_MEM, REG_E);
      emit_ld_r_r(REG_A, REG_HL_MEM);
      emit(8'h02);
    end
    run_program("reg_moves");
  endtask

  task automatic test_pair_ops();
    emit_ld_pair_imm(PAIR_BC, rand_data_addr());
    emit_ld_pair_imm(PAIR_DE, rand_data_addr());
    emit_ld_pair_imm(PAIR_HL, rand_data_addr());
    emit(8'h03);
    emit(8'h13);
    emit(8'h23);
    emit_ld_r_imm(REG_A, rand_byte());
    repeat (3) emit(8'h22);
    repeat (2) emit(8'h32);
    emit(8'h0A);
    emit(8'h22);
    emit(8'h1A);
    emit(8'h22);
    emit(8'h2A);
    emit(8'h12);
    emit(8'h3A);
    emit(8'h02);
    emit_ld_r_r(REG_E, REG_HL_MEM);
    emit_ld_r_r(REG_HL_MEM, REG_E);
    run_program("pair_ops");
  endtask

  task automatic test_cycle_timing();
    logic [7:0] odd_ops [12];
    odd_ops = '{8'h00, 8'h76, 8'h07, 8'h27, 8'h80, 8'hAF,
                8'hC3, 8'hE0, 8'hF0, 8'hEA, 8'hFA, 8'h33};
    emit_ld_r_imm(REG_A, rand_byte());
    emit_ld_pair_imm(PAIR_HL, rand_data_addr());
    for (int i = 0; i < 12; i++) begin
      emit(odd_ops[4'(i)]);
      emit_ld_r_r(REG_HL_MEM, REG_A);
    end
    run_program("cycle_timing");
  endtask

  initial begin
    rst_req      = 1'b0;
    load_en      = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    lfsr         = 32'h2831;
    fail_count   = 0;
    reset_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    r_list       = '{REG_B, REG_C, REG_D, REG_E, REG_H, REG_L, REG_A, REG_A};

    test_reset_state();
    if (!timed_out) test_imm_and_store();
    if (!timed_out) test_reg_moves();
    if (!timed_out) test_pair_ops();
    if (!timed_out) test_cycle_timing();

    $display("tests run: %0d, tests failed: %0d, failed checks: %0d",
             tests_run, tests_failed, total_errors());
    if (total_errors() == 0 && !timed_out) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
design/cpu_pkg.sv
design/instr_decoder.sv
design/mcycle_timer.sv
design/reg_file.sv
design/cpu_sequencer.sv
design/cpu_top.sv
tb/tb_clock_gen.sv
tb/tb_memory.sv
tb/cpu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = cpu_tb
FILELIST  = all.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
